// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module memCtrlTb -f memCtrl.f

run: build
	./obj_dir/VmemCtrlTb | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

lint:
	verilator --lint-only --timing --top-module memCtrlTb -f memCtrl.f

clean:
	rm -rf obj_dir sim.log

// File: memCtrl.f
source/memCtrlPkg.sv
source/memCtrlIf.sv
source/memArbiterFsm.sv
source/byteCounter.sv
source/memPortDriver.sv
source/loadAssembler.sv
source/memCtrlTop.sv
testbench/clockGen.sv
testbench/memCtrlChecker.sv
testbench/memCtrlProperties.sv
testbench/memCtrlTb.sv

// File: source/byteCounter.sv
`timescale 1ns/1ns

module byteCounter (
    input  logic              clk,
    input  logic              rst,
    input  memCtrlPkg::len_t  i_dcLen,
    memCtrlIf.counter         ctrl
);
    import memCtrlPkg::*;

    len_t   lenQ;
    index_t lastIdx;
    logic   issuedLast;

    assign lastIdx = index_t'(lenQ - 3'd1);

    assign ctrl.lastIssue   = (ctrl.issueIndex == lastIdx);
    // stays high once the final byte position is reached
    assign ctrl.lastCapture = (ctrl.returnIndex == lastIdx);
    assign ctrl.captureEn   = issuedLast && (ctrl.kind != STORE);

    always_ff @(posedge clk) begin
        if (rst) begin
            lenQ             <= len_t'(WORD_BYTES);
            ctrl.issueIndex  <= '0;
            ctrl.returnIndex <= '0;
            issuedLast       <= 1'b0;
        end else begin
            issuedLast <= ctrl.issueEn;
            if (ctrl.accept) begin
                lenQ             <= (ctrl.kind == FETCH) ? len_t'(WORD_BYTES) : i_dcLen;
                ctrl.issueIndex  <= '0;
                ctrl.returnIndex <= '0;
            end else begin
                if (ctrl.issueEn) begin
                    ctrl.issueIndex <= ctrl.issueIndex + 2'd1;
                end
                // hold on the last position so DRAIN can see it after a pause
                if (ctrl.captureEn && !ctrl.lastCapture) begin
                    ctrl.returnIndex <= ctrl.returnIndex + 2'd1;
                end
            end
        end
    end

endmodule

// File: source/loadAssembler.sv
`timescale 1ns/1ns

module loadAssembler (
    input  logic              clk,
    input  logic              rst,
    input  memCtrlPkg::byte_t i_memData,
    output logic              o_infDone,
    output memCtrlPkg::word_t o_infInst,
    output logic              o_dcDone,
    output memCtrlPkg::word_t o_dcData,
    memCtrlIf.assembler       ctrl
);
    import memCtrlPkg::*;

    word_t wordQ;

    // cleared per transfer so short loads come out zero-extended
    always_ff @(posedge clk) begin
        if (rst) begin
            wordQ <= '0;
        end else if (ctrl.accept) begin
            wordQ <= '0;
        end else if (ctrl.captureEn) begin
            wordQ[ctrl.returnIndex*BYTE_BITS +: BYTE_BITS] <= i_memData;
        end
    end

    assign o_infDone = ctrl.finish && (ctrl.kind == FETCH);
    assign o_dcDone  = ctrl.finish && (ctrl.kind != FETCH);

    assign o_infInst = o_infDone ? wordQ : '0;
    assign o_dcData  = o_dcDone ? wordQ : '0;

endmodule

// File: source/memArbiterFsm.sv
`timescale 1ns/1ns

module memArbiterFsm (
    input  logic clk,
    input  logic rst,
    input  logic i_dcEn,
    input  logic i_dcStore,
    input  logic i_infEn,
    input  logic i_rdy,
    input  logic i_ioBufferFull,
    memCtrlIf.fsm ctrl
);
    import memCtrlPkg::*;

    ctrlState_t state;
    txnKind_t   kindQ;
    txnKind_t   selKind;
    logic       pause;

    assign pause = !i_rdy || i_ioBufferFull;

    // data side wins a tie
    assign selKind = i_dcEn ? (i_dcStore ? STORE : LOAD) : FETCH;

    assign ctrl.accept  = (state == IDLE) && !pause && (i_dcEn || i_infEn);
    // new kind is visible during the accepting cycle
    assign ctrl.kind    = (state == IDLE) ? selKind : kindQ;
    assign ctrl.issueEn = (state == ISSUE) && !pause;
    assign ctrl.finish  = (state == FINISH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            kindQ <= FETCH;
        end else begin
            case (state)
                IDLE: begin
                    if (ctrl.accept) begin
                        state <= ISSUE;
                        kindQ <= selKind;
                    end
                end
                ISSUE: begin
                    if (!pause && ctrl.lastIssue) begin
                        // stores have nothing coming back
                        state <= (kindQ == STORE) ? FINISH : DRAIN;
                    end
                end
                DRAIN: begin
                    if (!pause && ctrl.lastCapture) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/memCtrlIf.sv
`timescale 1ns/1ns

interface memCtrlIf;
    import memCtrlPkg::*;

    logic     accept;
    txnKind_t kind;
    logic     issueEn;
    logic     finish;

    index_t   issueIndex;
    index_t   returnIndex;
    logic     captureEn;
    logic     lastIssue;
    logic     lastCapture;

    modport fsm (
        output accept, kind, issueEn, finish,
        input  lastIssue, lastCapture
    );

    modport counter (
        input  accept, kind, issueEn,
        output issueIndex, returnIndex, captureEn, lastIssue, lastCapture
    );

    modport port (input accept, kind, issueEn, issueIndex);

    modport assembler (input accept, kind, finish, captureEn, returnIndex);

endinterface

// File: source/memCtrlPkg.sv
package memCtrlPkg;

    localparam int BYTE_BITS  = 8;
    localparam int WORD_BYTES = 4;

    typedef logic [BYTE_BITS-1:0] byte_t;
    typedef logic [BYTE_BITS*WORD_BYTES-1:0] word_t;

    // legal lengths are 1, 2 and 4
    typedef logic [2:0] len_t;
    typedef logic [1:0] index_t;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } txnKind_t;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ISSUE  = 2'd1,
        DRAIN  = 2'd2,
        FINISH = 2'd3
    } ctrlState_t;

endpackage

// File: source/memCtrlTop.sv
`timescale 1ns/1ns

module memCtrlTop #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_rdy,
    input  logic                  i_ioBufferFull,

    // byte-wide RAM port
    input  memCtrlPkg::byte_t     i_memData,
    output logic                  o_memWrite,
    output logic [ADDR_WIDTH-1:0] o_memAddr,
    output memCtrlPkg::byte_t     o_memData,

    // instruction fetch
    input  logic                  i_infEn,
    input  logic [ADDR_WIDTH-1:0] i_infAddr,
    output logic                  o_infDone,
    output memCtrlPkg::word_t     o_infInst,

    // data cache
    input  logic                  i_dcEn,
    input  logic                  i_dcStore,
    input  memCtrlPkg::len_t      i_dcLen,
    input  memCtrlPkg::word_t     i_dcData,
    input  logic [ADDR_WIDTH-1:0] i_dcAddr,
    output logic                  o_dcDone,
    output memCtrlPkg::word_t     o_dcData
);

    memCtrlIf ctrl ();

    memArbiterFsm memArbiterFsm_inst (
        .clk            (clk),
        .rst            (rst),
        .i_dcEn         (i_dcEn),
        .i_dcStore      (i_dcStore),
        .i_infEn        (i_infEn),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .ctrl           (ctrl.fsm)
    );

    byteCounter byteCounter_inst (
        .clk     (clk),
        .rst     (rst),
        .i_dcLen (i_dcLen),
        .ctrl    (ctrl.counter)
    );

    memPortDriver #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) memPortDriver_inst (
        .clk        (clk),
        .rst        (rst),
        .i_infAddr  (i_infAddr),
        .i_dcAddr   (i_dcAddr),
        .i_dcData   (i_dcData),
        .o_memAddr  (o_memAddr),
        .o_memData  (o_memData),
        .o_memWrite (o_memWrite),
        .ctrl       (ctrl.port)
    );

    loadAssembler loadAssembler_inst (
        .clk       (clk),
        .rst       (rst),
        .i_memData (i_memData),
        .o_infDone (o_infDone),
        .o_infInst (o_infInst),
        .o_dcDone  (o_dcDone),
        .o_dcData  (o_dcData),
        .ctrl      (ctrl.assembler)
    );

endmodule

// File: source/memPortDriver.sv
`timescale 1ns/1ns

module memPortDriver #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [ADDR_WIDTH-1:0] i_infAddr,
    input  logic [ADDR_WIDTH-1:0] i_dcAddr,
    input  memCtrlPkg::word_t     i_dcData,
    output logic [ADDR_WIDTH-1:0] o_memAddr,
    output memCtrlPkg::byte_t     o_memData,
    output logic                  o_memWrite,
    memCtrlIf.port                ctrl
);
    import memCtrlPkg::*;

    logic [ADDR_WIDTH-1:0] baseQ;
    word_t                 storeQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            baseQ <= '0;
        end else if (ctrl.accept) begin
            baseQ <= (ctrl.kind == FETCH) ? i_infAddr : i_dcAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.accept && ctrl.kind == STORE) begin
            storeQ <= i_dcData;
        end
    end

    // little-endian so the low byte goes to the base address
    assign o_memAddr  = baseQ + ADDR_WIDTH'(ctrl.issueIndex);
    assign o_memData  = storeQ[ctrl.issueIndex*BYTE_BITS +: BYTE_BITS];
    assign o_memWrite = ctrl.issueEn && (ctrl.kind == STORE);

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
    parameter int PERIOD = 4
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule

// File: testbench/memCtrlChecker.sv
`timescale 1ns/1ns

module memCtrlChecker (
    input logic        clk,
    input logic        i_infDone,
    input logic [31:0] i_infInst,
    input logic        i_dcDone,
    input logic [31:0] i_dcData
);

    // side 0 is fetch, side 1 is data
    string       names [2];
    logic [31:0] expVals [2];
    bit          checkVals [2];
    int          expLats [2];
    int          waited [2];
    bit          armed [2] = '{1'b0, 1'b0};
    int          passCount = 0;
    int          failCount = 0;

    task automatic expectDone(input int side, input string name, input logic [31:0] value,
                              input bit checkVal, input int lat);
        names[side]     = name;
        expVals[side]   = value;
        checkVals[side] = checkVal;
        expLats[side]   = lat;
        waited[side]    = 0;
        armed[side]     = 1'b1;
    endtask

    task automatic compareWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            failCount++;
        end else begin
            $display("PASS %s", name);
            passCount++;
        end
    endtask

    task automatic judge(input int side, input logic [31:0] act);
        bit ok;
        ok = 1'b1;
        if (checkVals[side] && act !== expVals[side]) begin
            $display("Mismatch %s: expected %h, actual %h", names[side], expVals[side], act);
            ok = 1'b0;
        end
        if (expLats[side] >= 0 && waited[side] != expLats[side]) begin
            $display("Mismatch %s latency: expected %0d, actual %0d", names[side],
                     expLats[side], waited[side]);
            ok = 1'b0;
        end
        if (ok) begin
            $display("PASS %s", names[side]);
            passCount++;
        end else begin
            failCount++;
        end
        armed[side] = 1'b0;
    endtask

    always @(negedge clk) begin
        if (i_infDone && armed[1]) begin
            $display("%s: fetch finished while the data request was still waiting", names[1]);
            failCount++;
        end
        if (i_infDone) begin
            if (armed[0]) begin
                judge(0, i_infInst);
            end else begin
                $display("fetch done pulse arrived with no fetch pending");
                failCount++;
            end
        end else if (armed[0]) begin
            waited[0]++;
        end
        if (i_dcDone) begin
            if (armed[1]) begin
                judge(1, i_dcData);
            end else begin
                $display("data done pulse arrived with no data request pending");
                failCount++;
            end
        end else if (armed[1]) begin
            waited[1]++;
        end
    end

    task automatic printSummary();
        $display("tests run %0d, passed %0d, failed %0d", passCount + failCount, passCount,
                 failCount);
    endtask

endmodule

// File: testbench/memCtrlProperties.sv
`timescale 1ns/1ns

module memCtrlProperties (
    input logic clk,
    input logic rst,
    input logic i_rdy,
    input logic i_ioBufferFull,
    input logic o_memWrite,
    input logic o_infDone,
    input logic o_dcDone
);

    int assertFails = 0;

    noWriteInPause: assert property (@(posedge clk) disable iff (rst)
        o_memWrite |-> (i_rdy && !i_ioBufferFull))
        else begin
            $error("write strobe during a pause cycle");
            assertFails++;
        end

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(o_infDone && o_dcDone))
        else begin
            $error("both done outputs high together");
            assertFails++;
        end

    infDonePulse: assert property (@(posedge clk) disable iff (rst)
        o_infDone |=> !o_infDone)
        else begin
            $error("fetch done longer than one cycle");
            assertFails++;
        end

    dcDonePulse: assert property (@(posedge clk) disable iff (rst)
        o_dcDone |=> !o_dcDone)
        else begin
            $error("data done longer than one cycle");
            assertFails++;
        end

endmodule

bind memCtrlTop memCtrlProperties memCtrlProperties_inst (.*);

// File: testbench/memCtrlTb.sv
`timescale 1ns/1ns

module memCtrlTb;

    localparam int ADDR_WIDTH  = 16;
    localparam int RANDOM_TXNS = 40;
    localparam int TXN_COUNT   = RANDOM_TXNS + 10;
    localparam int MAX_PAUSE   = 8;
    localparam int CYCLE_LIMIT = TXN_COUNT * (6 + MAX_PAUSE) + 50;

    logic                  clk;
    logic                  rst;
    logic                  i_rdy;
    logic                  i_ioBufferFull;
    logic [7:0]            i_memData;
    logic                  o_memWrite;
    logic [ADDR_WIDTH-1:0] o_memAddr;
    logic [7:0]            o_memData;
    logic                  i_infEn;
    logic [ADDR_WIDTH-1:0] i_infAddr;
    logic                  o_infDone;
    logic [31:0]           o_infInst;
    logic                  i_dcEn;
    logic                  i_dcStore;
    logic [2:0]            i_dcLen;
    logic [31:0]           i_dcData;
    logic [ADDR_WIDTH-1:0] i_dcAddr;
    logic                  o_dcDone;
    logic [31:0]           o_dcData;

    logic [7:0]            ram [0:(1<<ADDR_WIDTH)-1];
    logic [7:0]            refMem [0:(1<<ADDR_WIDTH)-1];
    logic [ADDR_WIDTH-1:0] addrQ;
    logic [7:0]            dataQ;
    logic                  writeQ = 1'b0;
    logic [31:0]           lfsr = 32'd84592;
    int                    cycleCount = 0;

    clockGen #(.PERIOD(4)) clockGen_inst (.o_clk(clk));

    memCtrlTop #(.ADDR_WIDTH(ADDR_WIDTH)) memCtrlTop_inst (.*);

    memCtrlChecker memCtrlChecker_inst (
        .clk       (clk),
        .i_infDone (o_infDone),
        .i_infInst (o_infInst),
        .i_dcDone  (o_dcDone),
        .i_dcData  (o_dcData)
    );

    // RAM answers one cycle after the address
    always @(negedge clk) begin
        addrQ  = o_memAddr;
        dataQ  = o_memData;
        writeQ = o_memWrite;
    end

    always @(posedge clk) begin
        #1;
        if (writeQ) begin
            ram[addrQ] = dataQ;
        end
        i_memData = ram[addrQ];
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a done pulse never arrived", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] readBytes(input bit fromRam, input logic [15:0] base,
                                              input int len);
        logic [31:0] w;
        logic [15:0] a;
        w = '0;
        for (int i = 0; i < len; i++) begin
            a = base + 16'(i);
            w[i*8 +: 8] = fromRam ? ram[a] : refMem[a];
        end
        return w;
    endfunction

    task automatic runTxn(input string name, input bit useInf, input bit useDc,
                          input bit store, input logic [2:0] len, input logic [15:0] infA,
                          input logic [15:0] dcA, input logic [31:0] data, input bit pauses,
                          input int lat);
        bit          infPend;
        bit          dcPend;
        bit          sawInf;
        bit          sawDc;
        int          pauseLeft;
        logic [15:0] a;
        // data goes first, so a store is visible to the fetch
        if (useDc) begin
            if (store) begin
                for (int i = 0; i < int'(len); i++) begin
                    a = dcA + 16'(i);
                    refMem[a] = data[i*8 +: 8];
                end
            end
            memCtrlChecker_inst.expectDone(1, name, readBytes(0, dcA, int'(len)), !store, lat);
        end
        if (useInf) begin
            memCtrlChecker_inst.expectDone(0, name, readBytes(0, infA, 4), 1'b1,
                                           useDc ? -1 : lat);
        end
        i_infEn   = useInf;
        i_infAddr = infA;
        i_dcEn    = useDc;
        i_dcStore = store;
        i_dcLen   = len;
        i_dcAddr  = dcA;
        i_dcData  = data;
        infPend   = useInf;
        dcPend    = useDc;
        pauseLeft = pauses ? MAX_PAUSE : 0;
        while (infPend || dcPend) begin
            @(negedge clk);
            sawInf = o_infDone;
            sawDc  = o_dcDone;
            @(posedge clk);
            #1;
            if (sawInf) begin
                i_infEn = 1'b0;
                infPend = 1'b0;
            end
            if (sawDc) begin
                i_dcEn = 1'b0;
                dcPend = 1'b0;
            end
            i_rdy          = 1'b1;
            i_ioBufferFull = 1'b0;
            if (pauseLeft > 0 && randBits(2) == 0) begin
                pauseLeft--;
                if (randBits(1) == 1) begin
                    i_rdy = 1'b0;
                end else begin
                    i_ioBufferFull = 1'b1;
                end
            end
        end
        i_rdy          = 1'b1;
        i_ioBufferFull = 1'b0;
        if (useDc && store) begin
            memCtrlChecker_inst.compareWord({name, " ram"}, readBytes(0, dcA, int'(len)),
                                            readBytes(1, dcA, int'(len)));
        end
    endtask

    initial begin
        logic [1:0]  kindSel;
        logic [1:0]  lenSel;
        logic [2:0]  len;
        logic [15:0] addr;
        logic [15:0] addr2;
        logic [31:0] data;
        logic [1:0]  resetDones;
        for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
            ram[a]    = 8'(a * 3) ^ 8'(a >> 8) ^ 8'h5a;
            refMem[a] = ram[a];
        end
        rst = 1'b1;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        i_memData = '0;
        i_infEn = 1'b0;
        i_infAddr = '0;
        i_dcEn = 1'b0;
        i_dcStore = 1'b0;
        i_dcLen = 3'd4;
        i_dcData = '0;
        i_dcAddr = '0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        addr = 16'(randBits(16));
        runTxn("fetch", 1, 0, 0, 3'd4, addr, 0, 0, 0, 6);
        addr = 16'(randBits(16));
        runTxn("load byte", 0, 1, 0, 3'd1, 0, addr, 0, 0, 3);
        addr = 16'(randBits(16));
        runTxn("load half", 0, 1, 0, 3'd2, 0, addr, 0, 0, 4);
        addr = 16'(randBits(16));
        data = randBits(32);
        runTxn("store word", 0, 1, 1, 3'd4, 0, addr, data, 0, 5);
        runTxn("load back", 0, 1, 0, 3'd4, 0, addr, 0, 0, 6);
        addr  = 16'(randBits(16));
        addr2 = 16'(randBits(16));
        runTxn("both at once", 1, 1, 0, 3'd2, addr, addr2, 0, 0, 4);

        for (int t = 0; t < RANDOM_TXNS; t++) begin
            kindSel = 2'(randBits(2));
            lenSel  = 2'(randBits(2));
            len     = (lenSel == 0) ? 3'd1 : (lenSel == 1) ? 3'd2 : 3'd4;
            addr    = 16'(randBits(16));
            data    = randBits(32);
            if (kindSel == 0) begin
                runTxn($sformatf("random %0d", t), 1, 0, 0, 3'd4, addr, 0, 0, 1, -1);
            end else begin
                runTxn($sformatf("random %0d", t), 0, 1, kindSel[1], len, 0, addr, data, 1, -1);
            end
        end

        // reset in the middle of a fetch
        i_infEn   = 1'b1;
        i_infAddr = 16'(randBits(16));
        repeat (2) @(posedge clk);
        #1 rst = 1'b1;
        i_infEn = 1'b0;
        // window reaches past the cycle where the fetch would have finished
        resetDones = 2'b00;
        repeat (6) begin
            @(negedge clk);
            resetDones = resetDones | {o_infDone, o_dcDone};
        end
        memCtrlChecker_inst.compareWord("reset dones", 0, {30'd0, resetDones});
        @(posedge clk);
        #1 rst = 1'b0;
        addr = 16'(randBits(16));
        runTxn("after reset", 1, 0, 0, 3'd4, addr, 0, 0, 0, 6);

        memCtrlChecker_inst.printSummary();
        if (memCtrlChecker_inst.failCount == 0 &&
            memCtrlTop_inst.memCtrlProperties_inst.assertFails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
